/* run.sh */
#!/bin/sh
# Build the DMC channel testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f tb.f --top-module dmc_tb
out=$(./obj_dir/Vdmc_tb) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TESTS PASSED"

/* tb.f */
verilog/dmc_reg_pkg.sv
verilog/dmc_pkg.sv
verilog/dmc_control.sv
verilog/dmc_rate_timer.sv
verilog/dmc_sample_fetch.sv
verilog/dmc_output_unit.sv
verilog/dmc_channel.sv
test/dmc_clock_gen.sv
test/dmc_tb.sv

/* test/dmc_clock_gen.sv */
// Testbench clock and power-on reset generator
`default_nettype none

module dmc_clock_gen #(
	parameter int PERIOD       = 8,
	parameter int RESET_CYCLES = 5
) (
	output logic aclk,
	output logic reset
);

	initial begin
		aclk = 1'b0;
		forever #(PERIOD / 2) aclk = ~aclk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge aclk);
		reset <= 1'b0; // Released on a rising edge
	end

endmodule

`default_nettype wire

/* test/dmc_tb.sv */
// DMC channel testbench: directed tests, grant responder, delta model, compare tasks, watchdog
`default_nettype none

module dmc_tb;

	localparam int CLK_PERIOD    = 8;
	localparam int FAST_PERIOD   = 54; // Cycles per bit at rate 15
	localparam int BYTE_CYCLES   = 8 * FAST_PERIOD;
	localparam int TEST_BYTES    = 33 + 65 + 17 + 2 + 5;
	localparam int MARGIN_CYCLES = 20000;
	localparam int WATCHDOG_TIME = (TEST_BYTES * BYTE_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

	logic                       aclk;
	logic                       reset;
	logic                       reg_write;
	dmc_reg_pkg::dmc_reg_addr_t reg_addr;
	dmc_reg_pkg::dmc_data_t     reg_data;
	logic                       dma_grant;
	dmc_reg_pkg::dmc_data_t     dma_data;
	logic                       dma_req;
	dmc_pkg::dmc_addr_t         dma_addr;
	dmc_pkg::dmc_level_t        dmc_out;
	logic                       status_active;
	logic                       irq;

	logic [31:0]            lfsr_state;
	logic                   hold_grants; // Keeps requests pending for the disable check
	dmc_pkg::dmc_addr_t     grant_addr[$];
	dmc_reg_pkg::dmc_data_t grant_data[$];

	dmc_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) clock_gen (
		.aclk  (aclk),
		.reset (reset)
	);

	dmc_channel #(.RATE_TABLE_EN_NTSC(1'b1)) uut (
		.aclk          (aclk),
		.reset         (reset),
		.reg_write     (reg_write),
		.reg_addr      (reg_addr),
		.reg_data      (reg_data),
		.dma_grant     (dma_grant),
		.dma_data      (dma_data),
		.dma_req       (dma_req),
		.dma_addr      (dma_addr),
		.dmc_out       (dmc_out),
		.status_active (status_active),
		.irq           (irq)
	);

	task automatic end_in_failure();
		$display("TESTS FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_addr(input string name, input dmc_pkg::dmc_addr_t got,
	                          input dmc_pkg::dmc_addr_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
			end_in_failure();
		end
	endtask

	task automatic check_level(input string name, input dmc_pkg::dmc_level_t got,
	                           input dmc_pkg::dmc_level_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
			end_in_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
			end_in_failure();
		end
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic draw_bits(input int count, output logic [7:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value      = {value[6:0], lfsr_state[0]};
		end
	endtask

	// Clamped delta step for one sample bit
	function automatic dmc_pkg::dmc_level_t apply_delta_bit(input dmc_pkg::dmc_level_t level,
	                                                        input logic bit_val);
		if (bit_val)
			return (level <= 7'd125) ? level + 7'd2 : level;
		return (level >= 7'd2) ? level - 7'd2 : level;
	endfunction

	task automatic write_reg(input dmc_reg_pkg::dmc_reg_addr_t addr,
	                         input dmc_reg_pkg::dmc_data_t data);
		@(posedge aclk);
		reg_write <= 1'b1;
		reg_addr  <= addr;
		reg_data  <= data;
		@(posedge aclk);
		reg_write <= 1'b0;
	endtask

	task automatic clear_grants();
		grant_addr.delete();
		grant_data.delete();
	endtask

	task automatic wait_for_grants(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (grant_addr.size() < count) begin
			@(posedge aclk);
			cycles++;
			if (cycles > limit) begin
				$display("%0t: only %0d of %0d sample fetches were granted in time",
				         $time, grant_addr.size(), count);
				end_in_failure();
			end
		end
	endtask

	task automatic test_reset_and_load();
		check_level("dmc_out", dmc_out, 7'd0);
		check_bit("dma_req", dma_req, 1'b0);
		check_bit("irq", irq, 1'b0);
		check_bit("status_active", status_active, 1'b0);
		write_reg(dmc_reg_pkg::REG_LOAD, 8'hFF);
		@(posedge aclk);
		check_level("dmc_out", dmc_out, 7'd127); // Low 7 bits only
	endtask

	task automatic test_addressing();
		dmc_pkg::dmc_addr_t exp_addr;
		write_reg(dmc_reg_pkg::REG_CTRL, 8'h0F);
		write_reg(dmc_reg_pkg::REG_ADDR, 8'h10);
		write_reg(dmc_reg_pkg::REG_LEN, 8'h02);
		clear_grants();
		write_reg(dmc_reg_pkg::REG_STATUS, 8'h10);
		wait_for_grants(33, 36 * BYTE_CYCLES);
		repeat (2) @(posedge aclk);
		check_bit("status_active", status_active, 1'b0);
		check_bit("dma_req", dma_req, 1'b0);
		exp_addr = 16'hC400;
		foreach (grant_addr[i]) begin
			check_addr("dma_addr", grant_addr[i], exp_addr);
			exp_addr = exp_addr + 16'd1;
		end
		repeat (2 * BYTE_CYCLES) begin
			@(posedge aclk);
			check_bit("dma_req", dma_req, 1'b0);
		end
		if (grant_addr.size() != 33) begin
			$display("%0t: a byte was fetched after the sample ended", $time);
			end_in_failure();
		end
		hold_grants = 1'b1;
		write_reg(dmc_reg_pkg::REG_STATUS, 8'h10);
		@(posedge aclk);
		check_bit("dma_req", dma_req, 1'b0);
		@(posedge aclk);
		check_bit("dma_req", dma_req, 1'b1); // Request follows the restart cycle
		check_bit("status_active", status_active, 1'b1);
		write_reg(dmc_reg_pkg::REG_STATUS, 8'h00);
		@(posedge aclk);
		check_bit("dma_req", dma_req, 1'b0);
		check_bit("status_active", status_active, 1'b0);
		hold_grants = 1'b0;
	endtask

	task automatic test_address_wrap();
		dmc_pkg::dmc_addr_t exp_addr;
		write_reg(dmc_reg_pkg::REG_ADDR, 8'hFF);
		write_reg(dmc_reg_pkg::REG_LEN, 8'h04);
		clear_grants();
		write_reg(dmc_reg_pkg::REG_STATUS, 8'h10);
		wait_for_grants(65, 68 * BYTE_CYCLES);
		foreach (grant_addr[i]) begin
			if (i < 64)
				exp_addr = 16'hFFC0 + 16'(i); // Last 64 bytes of the address space
			else
				exp_addr = 16'h8000 + 16'(i - 64); // Continues at the bottom of ROM
			check_addr("dma_addr", grant_addr[i], exp_addr);
		end
	endtask

	task automatic test_delta_output();
		dmc_pkg::dmc_level_t expected;
		int b;
		expected = 7'd64;
		repeat (3 * BYTE_CYCLES) @(posedge aclk); // Previous sample plays out
		write_reg(dmc_reg_pkg::REG_LOAD, 8'd64);
		write_reg(dmc_reg_pkg::REG_ADDR, 8'h05);
		write_reg(dmc_reg_pkg::REG_LEN, 8'h01);
		check_level("dmc_out", dmc_out, 7'd64);
		clear_grants();
		write_reg(dmc_reg_pkg::REG_STATUS, 8'h10);
		wait_for_grants(17, 20 * BYTE_CYCLES);
		repeat (3 * BYTE_CYCLES + 2 * FAST_PERIOD) @(posedge aclk);
		foreach (grant_data[i])
			for (b = 0; b < 8; b++)
				expected = apply_delta_bit(expected, grant_data[i][b]); // LSB first
		check_level("dmc_out", dmc_out, expected);
	endtask

	task automatic test_interrupt();
		write_reg(dmc_reg_pkg::REG_CTRL, 8'h8F);
		write_reg(dmc_reg_pkg::REG_ADDR, 8'h20);
		write_reg(dmc_reg_pkg::REG_LEN, 8'h00);
		clear_grants();
		write_reg(dmc_reg_pkg::REG_STATUS, 8'h10);
		@(posedge aclk);
		check_bit("irq", irq, 1'b0);
		wait_for_grants(1, 3 * BYTE_CYCLES);
		repeat (3) @(posedge aclk);
		check_bit("irq", irq, 1'b1);
		write_reg(dmc_reg_pkg::REG_STATUS, 8'h00);
		@(posedge aclk);
		check_bit("irq", irq, 1'b0);
		write_reg(dmc_reg_pkg::REG_STATUS, 8'h10); // Second run
		wait_for_grants(2, 3 * BYTE_CYCLES);
		repeat (3) @(posedge aclk);
		check_bit("irq", irq, 1'b1);
		write_reg(dmc_reg_pkg::REG_CTRL, 8'h0F);
		@(posedge aclk);
		check_bit("irq", irq, 1'b0);
	endtask

	task automatic test_loop();
		int k;
		write_reg(dmc_reg_pkg::REG_CTRL, 8'hCF); // Loop with IRQ enabled
		write_reg(dmc_reg_pkg::REG_ADDR, 8'h00);
		write_reg(dmc_reg_pkg::REG_LEN, 8'h00);
		clear_grants();
		write_reg(dmc_reg_pkg::REG_STATUS, 8'h10);
		for (k = 1; k <= 5; k++) begin
			wait_for_grants(k, 3 * BYTE_CYCLES);
			repeat (2) @(posedge aclk);
			check_bit("irq", irq, 1'b0);
			check_bit("status_active", status_active, 1'b1);
		end
		foreach (grant_addr[i])
			check_addr("dma_addr", grant_addr[i], 16'hC000);
		write_reg(dmc_reg_pkg::REG_STATUS, 8'h00);
	endtask

	// Answers each request after 0 to 7 cycles with a pseudo-random byte
	initial begin : grant_responder
		logic [7:0] delay;
		logic [7:0] data_byte;
		lfsr_state = 32'h87bf45f3;
		dma_grant  = 1'b0;
		dma_data   = '0;
		forever begin
			@(posedge aclk);
			if (dma_req === 1'b1 && !hold_grants && reset === 1'b0) begin
				draw_bits(3, delay);
				repeat (delay) @(posedge aclk);
				if (dma_req === 1'b1) begin
					draw_bits(8, data_byte);
					dma_grant <= 1'b1;
					dma_data  <= data_byte;
					@(posedge aclk);
					grant_addr.push_back(dma_addr); // Address held until the grant edge
					grant_data.push_back(data_byte);
					dma_grant <= 1'b0;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("%0t: watchdog expired before the tests completed", $time);
		end_in_failure();
	end

	initial begin
		reg_write   = 1'b0;
		reg_addr    = '0;
		reg_data    = '0;
		hold_grants = 1'b0;
		@(posedge aclk);
		while (reset !== 1'b0)
			@(posedge aclk);
		test_reset_and_load();
		test_addressing();
		test_address_wrap();
		test_delta_output();
		test_interrupt();
		test_loop();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/dmc_channel.sv */
// Delta modulation channel top level: control, rate timer, fetch counters, output unit
`default_nettype none

module dmc_channel #(
	parameter bit RATE_TABLE_EN_NTSC = 1'b1
) (
	input  logic                       aclk,
	input  logic                       reset,
	input  logic                       reg_write,
	input  dmc_reg_pkg::dmc_reg_addr_t reg_addr,
	input  dmc_reg_pkg::dmc_data_t     reg_data,
	input  logic                       dma_grant,
	input  dmc_reg_pkg::dmc_data_t     dma_data,
	output logic                       dma_req,
	output dmc_pkg::dmc_addr_t         dma_addr,
	output dmc_pkg::dmc_level_t        dmc_out,
	output logic                       status_active,
	output logic                       irq
);

	dmc_reg_pkg::dmc_rate_idx_t rate_idx;
	logic tick;
	logic restart;
	logic byte_step;
	logic stop;
	logic sample_active;
	logic last_byte;
	logic buffer_full;
	logic buffer_load;

	assign status_active = sample_active; // Bytes remaining flag of $15

	dmc_control u_control (
		.aclk          (aclk),
		.reset         (reset),
		.reg_write     (reg_write),
		.reg_addr      (reg_addr),
		.reg_data      (reg_data),
		.dma_grant     (dma_grant),
		.sample_active (sample_active),
		.last_byte     (last_byte),
		.buffer_full   (buffer_full),
		.rate_idx      (rate_idx),
		.dma_req       (dma_req),
		.restart       (restart),
		.byte_step     (byte_step),
		.stop          (stop),
		.buffer_load   (buffer_load),
		.irq           (irq)
	);

	dmc_rate_timer #(
		.RATE_TABLE_EN_NTSC (RATE_TABLE_EN_NTSC)
	) u_rate_timer (
		.aclk     (aclk),
		.reset    (reset),
		.rate_idx (rate_idx),
		.tick     (tick)
	);

	dmc_sample_fetch u_sample_fetch (
		.aclk          (aclk),
		.reset         (reset),
		.reg_write     (reg_write),
		.reg_addr      (reg_addr),
		.reg_data      (reg_data),
		.restart       (restart),
		.byte_step     (byte_step),
		.stop          (stop),
		.dma_addr      (dma_addr),
		.sample_active (sample_active),
		.last_byte     (last_byte)
	);

	dmc_output_unit u_output_unit (
		.aclk        (aclk),
		.reset       (reset),
		.reg_write   (reg_write),
		.reg_addr    (reg_addr),
		.reg_data    (reg_data),
		.tick        (tick),
		.buffer_load (buffer_load),
		.dma_data    (dma_data),
		.buffer_full (buffer_full),
		.dmc_out     (dmc_out)
	);

endmodule

`default_nettype wire

/* verilog/dmc_control.sv */
// Channel control: $10 and $15 decode, interrupt flag and sample fetch FSM
`default_nettype none

module dmc_control (
	input  logic                        aclk,
	input  logic                        reset,
	input  logic                        reg_write,
	input  dmc_reg_pkg::dmc_reg_addr_t  reg_addr,
	input  dmc_reg_pkg::dmc_data_t      reg_data,
	input  logic                        dma_grant,
	input  logic                        sample_active,
	input  logic                        last_byte,
	input  logic                        buffer_full,
	output dmc_reg_pkg::dmc_rate_idx_t  rate_idx,
	output logic                        dma_req,
	output logic                        restart,
	output logic                        byte_step,
	output logic                        stop,
	output logic                        buffer_load,
	output logic                        irq
);

	logic ctrl_wr;
	logic status_wr;
	logic enable_bit;
	logic grant_ok;
	logic sample_end;
	logic loop_en;
	logic irq_en;
	dmc_pkg::dmc_fetch_state_t fetch_state;

	assign ctrl_wr    = reg_write && (reg_addr == dmc_reg_pkg::REG_CTRL);
	assign status_wr  = reg_write && (reg_addr == dmc_reg_pkg::REG_STATUS);
	assign enable_bit = reg_data[dmc_reg_pkg::STATUS_ENABLE_BIT];

	assign dma_req     = (fetch_state == dmc_pkg::FETCH_WAIT);
	assign grant_ok    = dma_grant && dma_req; // Stray grants are ignored
	assign buffer_load = grant_ok;
	assign sample_end  = grant_ok && last_byte;

	// Enabling only restarts a finished sample
	assign restart   = (status_wr && enable_bit && !sample_active) || (sample_end && loop_en);
	assign byte_step = grant_ok && !(last_byte && loop_en);
	assign stop      = status_wr && !enable_bit;

	always_ff @(posedge aclk) begin
		if (reset) begin
			rate_idx <= '0;
			loop_en  <= 1'b0;
			irq_en   <= 1'b0;
		end else if (ctrl_wr) begin
			rate_idx <= reg_data[dmc_reg_pkg::CTRL_RATE_MSB:dmc_reg_pkg::CTRL_RATE_LSB];
			loop_en  <= reg_data[dmc_reg_pkg::CTRL_LOOP_BIT];
			irq_en   <= reg_data[dmc_reg_pkg::CTRL_IRQ_EN_BIT];
		end
	end

	// Clearing by a register write takes precedence over a new sample end
	always_ff @(posedge aclk) begin
		if (reset)
			irq <= 1'b0;
		else if (status_wr || (ctrl_wr && !reg_data[dmc_reg_pkg::CTRL_IRQ_EN_BIT]))
			irq <= 1'b0;
		else if (sample_end && !loop_en && irq_en)
			irq <= 1'b1;
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			fetch_state <= dmc_pkg::FETCH_IDLE;
		end else begin
			case (fetch_state)
				dmc_pkg::FETCH_IDLE:
					if (sample_active && !buffer_full && !stop)
						fetch_state <= dmc_pkg::FETCH_WAIT; // Buffer empty with bytes left
				dmc_pkg::FETCH_WAIT:
					if (stop || dma_grant)
						fetch_state <= dmc_pkg::FETCH_IDLE;
				default:
					fetch_state <= dmc_pkg::FETCH_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/dmc_output_unit.sv */
// Output unit: $11 decode, sample buffer, shift register, bit counter, delta counter
`default_nettype none

module dmc_output_unit (
	input  logic                       aclk,
	input  logic                       reset,
	input  logic                       reg_write,
	input  dmc_reg_pkg::dmc_reg_addr_t reg_addr,
	input  dmc_reg_pkg::dmc_data_t     reg_data,
	input  logic                       tick,
	input  logic                       buffer_load,
	input  dmc_reg_pkg::dmc_data_t     dma_data,
	output logic                       buffer_full,
	output dmc_pkg::dmc_level_t        dmc_out
);

	dmc_reg_pkg::dmc_data_t sample_buf;
	dmc_reg_pkg::dmc_data_t shift_reg;
	logic [2:0]             bit_cnt;
	logic                   silent;
	logic                   cycle_end;

	assign cycle_end = (bit_cnt == 3'd7);

	always_ff @(posedge aclk) begin
		if (buffer_load)
			sample_buf <= dma_data;
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			shift_reg   <= '0;
			bit_cnt     <= '0;
			silent      <= 1'b1;
			buffer_full <= 1'b0;
		end else begin
			if (tick) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (cycle_end) begin
					// Start of a new 8-bit output cycle
					if (buffer_full) begin
						shift_reg   <= sample_buf;
						buffer_full <= 1'b0;
						silent      <= 1'b0;
					end else begin
						silent <= 1'b1; // Nothing fetched in time
					end
				end else if (!silent) begin
					shift_reg <= {1'b0, shift_reg[7:1]};
				end
			end
			if (buffer_load)
				buffer_full <= 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			dmc_out <= '0;
		end else if (reg_write && (reg_addr == dmc_reg_pkg::REG_LOAD)) begin
			dmc_out <= reg_data[6:0]; // Direct load wins over a tick
		end else if (tick && !silent) begin
			if (shift_reg[0] && (dmc_out <= 7'd125))
				dmc_out <= dmc_out + 7'd2;
			else if (!shift_reg[0] && (dmc_out >= 7'd2))
				dmc_out <= dmc_out - 7'd2;
		end
	end

endmodule

`default_nettype wire

/* verilog/dmc_pkg.sv */
// Channel datapath types, fetch state enum and rate period tables
`default_nettype none

package dmc_pkg;

	typedef logic [15:0] dmc_addr_t;  // Sample fetch address
	typedef logic [11:0] dmc_len_t;   // Bytes remaining
	typedef logic [6:0]  dmc_level_t; // Output level for the DAC
	typedef logic [8:0]  dmc_period_t; // Bit clock period in cycles

	// Bit clock periods with the slowest rate at index 0
	localparam dmc_period_t RATE_PERIOD [16] = '{
		9'd428, 9'd380, 9'd340, 9'd320, 9'd286, 9'd254, 9'd226, 9'd214,
		9'd190, 9'd160, 9'd142, 9'd128, 9'd106, 9'd84,  9'd72,  9'd54
	};

	// Same table for the 50 Hz console
	localparam dmc_period_t RATE_PERIOD_PAL [16] = '{
		9'd398, 9'd354, 9'd316, 9'd298, 9'd276, 9'd236, 9'd210, 9'd198,
		9'd176, 9'd148, 9'd132, 9'd118, 9'd98,  9'd78,  9'd66,  9'd50
	};

	localparam dmc_addr_t ADDR_BASE = 16'hC000; // Start of sample space
	localparam dmc_addr_t ADDR_WRAP = 16'h8000; // Counter wraps here past $FFFF

	typedef enum logic {
		FETCH_IDLE,
		FETCH_WAIT
	} dmc_fetch_state_t;

endpackage

`default_nettype wire

/* verilog/dmc_rate_timer.sv */
// Bit clock timer: period table lookup and down counter with tick output
`default_nettype none

module dmc_rate_timer #(
	parameter bit RATE_TABLE_EN_NTSC = 1'b1
) (
	input  logic                       aclk,
	input  logic                       reset,
	input  dmc_reg_pkg::dmc_rate_idx_t rate_idx,
	output logic                       tick
);

	dmc_pkg::dmc_period_t period;
	dmc_pkg::dmc_period_t count;

	assign period = RATE_TABLE_EN_NTSC ? dmc_pkg::RATE_PERIOD[rate_idx]
	                                   : dmc_pkg::RATE_PERIOD_PAL[rate_idx];

	// A new rate takes effect at the next reload
	always_ff @(posedge aclk) begin
		if (reset) begin
			count <= '0;
			tick  <= 1'b0;
		end else if (count == '0) begin
			count <= period - 9'd1;
			tick  <= 1'b1;
		end else begin
			count <= count - 9'd1;
			tick  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* verilog/dmc_reg_pkg.sv */
// CPU register offsets, register field positions and register field types
`default_nettype none

package dmc_reg_pkg;

	// Low bits of the CPU register address
	typedef logic [4:0] dmc_reg_addr_t;

	// CPU data byte
	typedef logic [7:0] dmc_data_t;

	// Rate index field of $10
	typedef logic [3:0] dmc_rate_idx_t;

	localparam dmc_reg_addr_t REG_CTRL   = 5'h10; // Rate, loop, IRQ enable
	localparam dmc_reg_addr_t REG_LOAD   = 5'h11; // Direct output load
	localparam dmc_reg_addr_t REG_ADDR   = 5'h12; // Sample start address
	localparam dmc_reg_addr_t REG_LEN    = 5'h13; // Sample length
	localparam dmc_reg_addr_t REG_STATUS = 5'h15; // Channel enable

	localparam int CTRL_IRQ_EN_BIT   = 7;
	localparam int CTRL_LOOP_BIT     = 6;
	localparam int STATUS_ENABLE_BIT = 4; // Same bit reads back as active

	// Rate field occupies the low nibble of $10
	localparam int CTRL_RATE_LSB = 0;
	localparam int CTRL_RATE_MSB = 3;

endpackage

`default_nettype wire

/* verilog/dmc_sample_fetch.sv */
// Sample fetch counters: $12 and $13 decode, address counter, remaining count
`default_nettype none

module dmc_sample_fetch (
	input  logic                       aclk,
	input  logic                       reset,
	input  logic                       reg_write,
	input  dmc_reg_pkg::dmc_reg_addr_t reg_addr,
	input  dmc_reg_pkg::dmc_data_t     reg_data,
	input  logic                       restart,
	input  logic                       byte_step,
	input  logic                       stop,
	output dmc_pkg::dmc_addr_t         dma_addr,
	output logic                       sample_active,
	output logic                       last_byte
);

	dmc_reg_pkg::dmc_data_t start_reg;
	dmc_reg_pkg::dmc_data_t length_reg;
	dmc_pkg::dmc_len_t      remaining;

	always_ff @(posedge aclk) begin
		if (reg_write && (reg_addr == dmc_reg_pkg::REG_ADDR))
			start_reg <= reg_data;
		if (reg_write && (reg_addr == dmc_reg_pkg::REG_LEN))
			length_reg <= reg_data;
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			dma_addr  <= dmc_pkg::ADDR_BASE;
			remaining <= '0;
		end else if (restart) begin
			dma_addr  <= dmc_pkg::ADDR_BASE + {2'b00, start_reg, 6'b000000}; // 64-byte steps
			remaining <= {length_reg, 4'b0000} + 12'd1; // 16n + 1 bytes
		end else begin
			if (byte_step)
				dma_addr <= (dma_addr == 16'hFFFF) ? dmc_pkg::ADDR_WRAP : dma_addr + 16'd1;
			if (stop)
				remaining <= '0;
			else if (byte_step)
				remaining <= remaining - 12'd1;
		end
	end

	assign sample_active = (remaining != '0);
	assign last_byte     = (remaining == 12'd1);

endmodule

`default_nettype wire
